//--- vlog.f
+incdir+src
+incdir+test
src/core_types_pkg.sv
src/ldu_types_pkg.sv
src/ldu_dispatch_select.sv
src/ldu_dq_queue.sv
src/ldu_dq_enq.sv
src/ldu_dq_wrapper.sv
test/tb_ldu_dq.sv

//--- test/tb_ldu_dq_checks.svh
// typed compare tasks for the load dispatch queue testbench
// dispatch acks, central queue and issue queue enqueues

`ifndef TB_LDU_DQ_CHECKS_SVH
`define TB_LDU_DQ_CHECKS_SVH

	// print the reason and stop
	task automatic abort_run(string msg);
		$display("%s", msg);
		$display("TB FAILED");
		$fatal(1);
	endtask

	task automatic compare_ack(logic [`LDU_DISPATCH_WAYS-1:0] got,
			logic [`LDU_DISPATCH_WAYS-1:0] exp);
		if (got !== exp) begin
			abort_run($sformatf("FAIL %0t: dispatch ack %b, expected %b", $time, got, exp));
		end
	endtask

	task automatic compare_cq_enq(ldu_types_pkg::ldu_cq_enq_t got,
			ldu_types_pkg::ldu_cq_enq_t exp);
		if (got !== exp) begin
			abort_run($sformatf("FAIL %0t: central queue enqueue %h, expected %h (ROB %0d)",
				$time, got, exp, exp.ROB_index));
		end
	endtask

	task automatic compare_iq_enq(ldu_types_pkg::ldu_iq_enq_t got,
			ldu_types_pkg::ldu_iq_enq_t exp);
		if (got !== exp) begin
			abort_run($sformatf("FAIL %0t: issue queue enqueue %h, expected %h",
				$time, got, exp));
		end
	endtask

`endif

//--- test/tb_ldu_dq.sv
// testbench for the load dispatch queue wrapper
// stimulus table, reference model, enqueue order checks

`timescale 1ns/1ns

`include "ldu_macros.svh"

module tb_ldu_dq;

	localparam int WAYS = `LDU_DISPATCH_WAYS;
	localparam int DEPTH = `LDU_DQ_ENTRIES;
	localparam int BANKS = `LDU_PRF_BANK_COUNT;
	localparam int ROB = `LDU_ROB_ENTRIES;
	localparam int N_SPEC = 25;
	localparam int TIMEOUT = 60;

	typedef struct packed {
		logic [WAYS-1:0] attempt;
		logic [WAYS-1:0] valid;
		logic wake;
		logic kill;
		logic cq_ready;
		logic iq_ready;
	} spec_t;

	typedef struct packed {
		ldu_types_pkg::ldu_dispatch_op_t [WAYS-1:0] ways;
		core_types_pkg::wb_bus_by_bank_t wb;
		core_types_pkg::rob_kill_t kill;
		logic cq_ready;
		logic iq_ready;
		core_types_pkg::cq_index_t cq_index;
	} row_t;

	logic CLK;
	logic nRST;
	row_t drive;
	logic [WAYS-1:0] last_dispatch_ack_by_way;
	ldu_types_pkg::ldu_cq_enq_t last_ldu_cq_enq;
	ldu_types_pkg::ldu_iq_enq_t last_ldu_iq_enq;

	logic [15:0] lfsr_state;
	core_types_pkg::rob_index_t rob_ctr;
	core_types_pkg::pr_t last_a_pr;
	int cycle;
	row_t rows [N_SPEC];

	// reference model state and expected results
	ldu_types_pkg::ldu_dq_entry_t model_q [$];
	logic [WAYS-1:0] ack_q [$];
	ldu_types_pkg::ldu_cq_enq_t cq_q [$];
	ldu_types_pkg::ldu_iq_enq_t iq_q [$];

	// columns: attempt, valid, wake, kill, cq ready, iq ready
	spec_t spec [N_SPEC] = '{
		12'b0001_0001_00_11, 12'b0011_0011_00_11, 12'b0101_0100_00_11,
		12'b1111_1111_00_11, 12'b0001_0001_10_11,
		// back-pressure, wake a stored op, fill, then kill
		12'b0001_0001_00_00, 12'b0000_0000_10_00, 12'b0001_0001_00_00,
		12'b0001_0001_00_00, 12'b0001_0001_00_00, 12'b0000_0000_01_00,
		12'b1111_1111_00_00, 12'b0000_0000_00_10, 12'b0001_0001_00_11,
		// killed heads leave without issue queue ready
		12'b0000_0000_00_10, 12'b0000_0000_00_10, 12'b0000_0000_00_00,
		12'b0000_0000_00_10, 12'b0011_0011_00_01, 12'b0111_0010_00_11,
		12'b1000_1000_00_10, 12'b0001_0001_00_01, 12'b0010_0010_10_11,
		12'b1100_1100_00_11, 12'b0001_0001_01_11
	};

	ldu_dq_wrapper dut0 (
		.CLK(CLK),
		.nRST(nRST),
		.next_dispatch_by_way(drive.ways),
		.last_dispatch_ack_by_way(last_dispatch_ack_by_way),
		.next_wb_bus_by_bank(drive.wb),
		.next_rob_kill(drive.kill),
		.next_ldu_cq_enq_ready(drive.cq_ready),
		.next_ldu_cq_enq_index(drive.cq_index),
		.last_ldu_cq_enq(last_ldu_cq_enq),
		.next_ldu_iq_enq_ready(drive.iq_ready),
		.last_ldu_iq_enq(last_ldu_iq_enq)
	);

	`include "tb_ldu_dq_checks.svh"

	initial begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;
	end

	// x^16 + x^14 + x^13 + x^11, one step per bit
	function automatic logic [15:0] rand_bits(int n);
		logic [15:0] r;
		logic fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
			lfsr_state = {lfsr_state[14:0], fb};
			r = {r[14:0], fb};
		end
		return r;
	endfunction

	function automatic row_t build_row(spec_t s);
		row_t r;
		logic found;
		int bank;
		r = '0;
		found = 1'b0;
		for (int w = 0; w < WAYS; w++) begin
			r.ways[w].attempt = s.attempt[w];
			r.ways[w].valid = s.valid[w];
			r.ways[w].op = 4'(rand_bits(4));
			r.ways[w].imm12 = 12'(rand_bits(12));
			r.ways[w].mdp_info = 8'(rand_bits(8));
			r.ways[w].A_PR = 6'(rand_bits(6));
			r.ways[w].A_is_zero = 1'(rand_bits(1));
			r.ways[w].dest_PR = 6'(rand_bits(6));
			if (s.valid[w]) begin
				r.ways[w].ROB_index = rob_ctr;
				rob_ctr = rob_ctr + 1'b1;
			end
			// the way the selector takes first
			if (s.attempt[w] && s.valid[w] && !found) begin
				last_a_pr = r.ways[w].A_PR;
				found = 1'b1;
			end
		end
		if (s.wake) begin
			bank = last_a_pr % BANKS;
			r.wb[bank].valid = 1'b1;
			r.wb[bank].upper_PR = 4'(last_a_pr / BANKS);
		end
		// kills the three newest ROB indices
		if (s.kill) begin
			r.kill.valid = 1'b1;
			r.kill.abs_head_index = rob_ctr;
			r.kill.rel_kill_younger_index = 5'(ROB - 3);
		end
		r.cq_ready = s.cq_ready;
		r.iq_ready = s.iq_ready;
		r.cq_index = 4'(rand_bits(4));
		return r;
	endfunction

	// --------------------
	// reference model
	function automatic logic wakes(core_types_pkg::pr_t pr, core_types_pkg::wb_bus_by_bank_t wb);
		return wb[pr % BANKS].valid && (wb[pr % BANKS].upper_PR == pr / BANKS);
	endfunction

	function automatic logic kills(core_types_pkg::rob_index_t rob, core_types_pkg::rob_kill_t k);
		int rel;
		rel = (int'(rob) - int'(k.abs_head_index) + ROB) % ROB;
		return k.valid && (rel >= int'(k.rel_kill_younger_index));
	endfunction

	task automatic model_step(row_t r);
		logic [WAYS-1:0] ack;
		logic pop;
		logic blocked;
		logic taken;
		int sel;
		ldu_types_pkg::ldu_dq_entry_t e;
		ldu_types_pkg::ldu_cq_enq_t c;
		ldu_types_pkg::ldu_iq_enq_t q;
		ack = '0;
		blocked = 1'b0;
		taken = 1'b0;
		sel = 0;
		pop = (model_q.size() != 0) && r.cq_ready && (r.iq_ready || model_q[0].killed);
		for (int w = 0; w < WAYS; w++) begin
			if (r.ways[w].attempt && !blocked) begin
				if (!r.ways[w].valid) begin
					ack[w] = 1'b1;
				end else if (!taken && (model_q.size() < DEPTH || pop)) begin
					ack[w] = 1'b1;
					taken = 1'b1;
					sel = w;
				end else begin
					blocked = 1'b1;
				end
			end
		end
		ack_q.push_back(ack);
		if (pop) begin
			e = model_q.pop_front();
			c = {1'b1, e.killed, e.mdp_info, e.dest_PR, e.ROB_index};
			cq_q.push_back(c);
			if (!e.killed) begin
				q = {1'b1, e.op, e.imm12, e.A_PR, e.A_ready || wakes(e.A_PR, r.wb),
					e.A_is_zero, r.cq_index};
				iq_q.push_back(q);
			end
		end
		foreach (model_q[i]) begin
			e = model_q[i];
			e.A_ready = e.A_ready || wakes(e.A_PR, r.wb);
			e.killed = e.killed || kills(e.ROB_index, r.kill);
			model_q[i] = e;
		end
		if (taken) begin
			e.op = r.ways[sel].op;
			e.imm12 = r.ways[sel].imm12;
			e.mdp_info = r.ways[sel].mdp_info;
			e.A_PR = r.ways[sel].A_PR;
			e.A_ready = r.ways[sel].A_ready || wakes(r.ways[sel].A_PR, r.wb);
			e.A_is_zero = r.ways[sel].A_is_zero;
			e.dest_PR = r.ways[sel].dest_PR;
			e.ROB_index = r.ways[sel].ROB_index;
			e.killed = kills(r.ways[sel].ROB_index, r.kill);
			model_q.push_back(e);
		end
	endtask

	// --------------------
	// one clock of stimulus and checks
	task automatic run_cycle(row_t r);
		@(posedge CLK);
		#2;
		drive = r;
		model_step(r);
		@(negedge CLK);
		cycle++;
		// acks show two edges after the drive
		if (cycle > 2) begin
			compare_ack(last_dispatch_ack_by_way, ack_q.pop_front());
		end
		if (last_ldu_cq_enq.valid) begin
			if (cq_q.size() == 0) begin
				abort_run("central queue enqueue seen with none expected");
			end else begin
				compare_cq_enq(last_ldu_cq_enq, cq_q.pop_front());
			end
		end
		if (last_ldu_iq_enq.valid) begin
			if (iq_q.size() == 0) begin
				abort_run("issue queue enqueue seen with none expected");
			end else begin
				compare_iq_enq(last_ldu_iq_enq, iq_q.pop_front());
			end
		end
	endtask

	initial begin
		row_t idle;
		int waited;
		lfsr_state = 16'd34113;
		rob_ctr = '0;
		last_a_pr = '0;
		cycle = 0;
		drive = '0;
		nRST = 1'b0;
		foreach (spec[i]) begin
			rows[i] = build_row(spec[i]);
		end
		repeat (3) @(posedge CLK);
		#2;
		nRST = 1'b1;
		@(negedge CLK);
		compare_ack(last_dispatch_ack_by_way, '0);
		if (last_ldu_cq_enq.valid || last_ldu_iq_enq.valid) begin
			abort_run("enqueue valid is high right after reset");
		end
		foreach (rows[i]) begin
			run_cycle(rows[i]);
		end
		// drain with both queues ready
		idle = '0;
		idle.cq_ready = 1'b1;
		idle.iq_ready = 1'b1;
		waited = 0;
		while (cq_q.size() != 0 || iq_q.size() != 0) begin
			if (waited >= TIMEOUT) begin
				abort_run("timed out waiting for the outstanding enqueues");
			end else begin
				run_cycle(idle);
				waited++;
			end
		end
		repeat (4) run_cycle(idle);
		$display("TB PASSED");
		$finish;
	end

endmodule

//--- src/ldu_dq_wrapper.sv
// load dispatch queue top level
// boundary registers around selector, queue and enqueue stage

`timescale 1ns/1ns

`include "ldu_macros.svh"

module ldu_dq_wrapper (
	input logic CLK,
	input logic nRST,

	// dispatch ways
	input ldu_types_pkg::ldu_dispatch_op_t [`LDU_DISPATCH_WAYS-1:0] next_dispatch_by_way,
	output logic [`LDU_DISPATCH_WAYS-1:0] last_dispatch_ack_by_way,

	// broadcasts
	input core_types_pkg::wb_bus_by_bank_t next_wb_bus_by_bank,
	input core_types_pkg::rob_kill_t next_rob_kill,

	// central queue
	input logic next_ldu_cq_enq_ready,
	input core_types_pkg::cq_index_t next_ldu_cq_enq_index,
	output ldu_types_pkg::ldu_cq_enq_t last_ldu_cq_enq,

	// issue queue
	input logic next_ldu_iq_enq_ready,
	output ldu_types_pkg::ldu_iq_enq_t last_ldu_iq_enq
);

	// registered inputs
	ldu_types_pkg::ldu_dispatch_op_t [`LDU_DISPATCH_WAYS-1:0] dispatch_by_way;
	core_types_pkg::wb_bus_by_bank_t wb_bus_by_bank;
	core_types_pkg::rob_kill_t rob_kill;
	logic ldu_cq_enq_ready;
	core_types_pkg::cq_index_t ldu_cq_enq_index;
	logic ldu_iq_enq_ready;

	// core logic outputs
	logic [`LDU_DISPATCH_WAYS-1:0] dispatch_ack_by_way;
	ldu_types_pkg::ldu_cq_enq_t ldu_cq_enq;
	ldu_types_pkg::ldu_iq_enq_t ldu_iq_enq;

	// between blocks
	logic write_valid;
	ldu_types_pkg::ldu_dq_entry_t write_entry;
	logic full;
	logic head_valid;
	ldu_types_pkg::ldu_dq_entry_t head_entry;
	logic pop;

	// --------------------
	// blocks
	ldu_dispatch_select u_select (
		.dispatch_by_way(dispatch_by_way),
		.full(full),
		.dispatch_ack_by_way(dispatch_ack_by_way),
		.write_valid(write_valid),
		.write_entry(write_entry)
	);

	ldu_dq_queue u_queue (
		.CLK(CLK),
		.nRST(nRST),
		.write_valid(write_valid),
		.write_entry(write_entry),
		.pop(pop),
		.wb_bus_by_bank(wb_bus_by_bank),
		.rob_kill(rob_kill),
		.full(full),
		.head_valid(head_valid),
		.head_entry(head_entry)
	);

	ldu_dq_enq u_enq (
		.head_valid(head_valid),
		.head_entry(head_entry),
		.wb_bus_by_bank(wb_bus_by_bank),
		.ldu_cq_enq_ready(ldu_cq_enq_ready),
		.ldu_cq_enq_index(ldu_cq_enq_index),
		.ldu_iq_enq_ready(ldu_iq_enq_ready),
		.pop(pop),
		.ldu_cq_enq(ldu_cq_enq),
		.ldu_iq_enq(ldu_iq_enq)
	);

	// --------------------
	// boundary registers
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			dispatch_by_way <= '0;
			wb_bus_by_bank <= '0;
			rob_kill <= '0;
			ldu_cq_enq_ready <= 1'b0;
			ldu_cq_enq_index <= '0;
			ldu_iq_enq_ready <= 1'b0;
			last_dispatch_ack_by_way <= '0;
			last_ldu_cq_enq <= '0;
			last_ldu_iq_enq <= '0;
		end else begin
			// inputs
			dispatch_by_way <= next_dispatch_by_way;
			wb_bus_by_bank <= next_wb_bus_by_bank;
			rob_kill <= next_rob_kill;
			ldu_cq_enq_ready <= next_ldu_cq_enq_ready;
			ldu_cq_enq_index <= next_ldu_cq_enq_index;
			ldu_iq_enq_ready <= next_ldu_iq_enq_ready;
			// outputs
			last_dispatch_ack_by_way <= dispatch_ack_by_way;
			last_ldu_cq_enq <= ldu_cq_enq;
			last_ldu_iq_enq <= ldu_iq_enq;
		end
	end

endmodule

//--- src/ldu_dq_enq.sv
// head pop into the load central queue and issue queue
// killed ops only go to the central queue

`timescale 1ns/1ns

module ldu_dq_enq (
	input logic head_valid,
	input ldu_types_pkg::ldu_dq_entry_t head_entry,
	input core_types_pkg::wb_bus_by_bank_t wb_bus_by_bank,
	input logic ldu_cq_enq_ready,
	input core_types_pkg::cq_index_t ldu_cq_enq_index,
	input logic ldu_iq_enq_ready,

	output logic pop,
	output ldu_types_pkg::ldu_cq_enq_t ldu_cq_enq,
	output ldu_types_pkg::ldu_iq_enq_t ldu_iq_enq
);

	logic head_A_ready;

	// killed head does not wait on the issue queue
	assign pop = head_valid && ldu_cq_enq_ready
		&& (ldu_iq_enq_ready || head_entry.killed);

	// wakeup landing in the pop cycle
	assign head_A_ready = head_entry.A_ready
		|| core_types_pkg::pr_woken(head_entry.A_PR, wb_bus_by_bank);

	// --------------------
	// central queue
	always_comb begin
		ldu_cq_enq.valid = pop;
		ldu_cq_enq.killed = head_entry.killed;
		ldu_cq_enq.mdp_info = head_entry.mdp_info;
		ldu_cq_enq.dest_PR = head_entry.dest_PR;
		ldu_cq_enq.ROB_index = head_entry.ROB_index;
	end

	// --------------------
	// issue queue
	always_comb begin
		ldu_iq_enq.valid = pop && !head_entry.killed;
		ldu_iq_enq.op = head_entry.op;
		ldu_iq_enq.imm12 = head_entry.imm12;
		ldu_iq_enq.A_PR = head_entry.A_PR;
		ldu_iq_enq.A_ready = head_A_ready;
		ldu_iq_enq.A_is_zero = head_entry.A_is_zero;
		// index handed back with the ready
		ldu_iq_enq.cq_index = ldu_cq_enq_index;
	end

endmodule

//--- src/ldu_dq_queue.sv
// circular load dispatch queue
// operand wakeup and kill marking on stored and incoming ops

`timescale 1ns/1ns

`include "ldu_macros.svh"

module ldu_dq_queue (
	input logic CLK,
	input logic nRST,

	input logic write_valid,
	input ldu_types_pkg::ldu_dq_entry_t write_entry,
	input logic pop,
	input core_types_pkg::wb_bus_by_bank_t wb_bus_by_bank,
	input core_types_pkg::rob_kill_t rob_kill,

	output logic full,
	output logic head_valid,
	output ldu_types_pkg::ldu_dq_entry_t head_entry
);

	localparam int DEPTH = `LDU_DQ_ENTRIES;
	localparam int PTR_W = $clog2(DEPTH);

	ldu_types_pkg::ldu_dq_entry_t entries [DEPTH];
	ldu_types_pkg::ldu_dq_entry_t write_entry_upd;

	logic [PTR_W-1:0] head_ptr;
	logic [PTR_W-1:0] tail_ptr;
	logic [PTR_W:0] count;

	// a pop this cycle frees the head slot for the incoming op
	assign full = (count == (PTR_W+1)'(DEPTH)) && !pop;
	assign head_valid = (count != '0);
	assign head_entry = entries[head_ptr];

	// incoming op sees the same broadcasts as stored ones
	always_comb begin
		write_entry_upd = write_entry;
		if (core_types_pkg::pr_woken(write_entry.A_PR, wb_bus_by_bank)) begin
			write_entry_upd.A_ready = 1'b1;
		end
		if (core_types_pkg::rob_killed(write_entry.ROB_index, rob_kill)) begin
			write_entry_upd.killed = 1'b1;
		end
	end

	// --------------------
	// storage
	always_ff @(posedge CLK) begin
		for (int i = 0; i < DEPTH; i++) begin
			if (core_types_pkg::pr_woken(entries[i].A_PR, wb_bus_by_bank)) begin
				entries[i].A_ready <= 1'b1;
			end
			if (core_types_pkg::rob_killed(entries[i].ROB_index, rob_kill)) begin
				entries[i].killed <= 1'b1;
			end
		end
		// new op overrides the tail slot
		if (write_valid) begin
			entries[tail_ptr] <= write_entry_upd;
		end
	end

	// --------------------
	// pointers and occupancy
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			head_ptr <= '0;
			tail_ptr <= '0;
			count <= '0;
		end else begin
			if (pop) begin
				head_ptr <= (head_ptr == PTR_W'(DEPTH-1)) ? '0 : head_ptr + 1'b1;
			end
			if (write_valid) begin
				tail_ptr <= (tail_ptr == PTR_W'(DEPTH-1)) ? '0 : tail_ptr + 1'b1;
			end
			case ({write_valid, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

//--- src/ldu_dispatch_select.sv
// in-order dispatch acknowledge over the load ways
// picks at most one op per cycle for the dispatch queue

`timescale 1ns/1ns

`include "ldu_macros.svh"

module ldu_dispatch_select (
	input ldu_types_pkg::ldu_dispatch_op_t [`LDU_DISPATCH_WAYS-1:0] dispatch_by_way,
	input logic full,

	output logic [`LDU_DISPATCH_WAYS-1:0] dispatch_ack_by_way,
	output logic write_valid,
	output ldu_types_pkg::ldu_dq_entry_t write_entry
);

	localparam int SEL_W = $clog2(`LDU_DISPATCH_WAYS);

	logic blocked;
	logic taken;
	logic [SEL_W-1:0] sel_way;
	ldu_types_pkg::ldu_dispatch_op_t sel_op;

	// scan lowest way first
	always_comb begin
		blocked = 1'b0;
		taken = 1'b0;
		sel_way = '0;
		dispatch_ack_by_way = '0;
		for (int w = 0; w < `LDU_DISPATCH_WAYS; w++) begin
			if (dispatch_by_way[w].attempt && !blocked) begin
				if (!dispatch_by_way[w].valid) begin
					// invalid attempt, ack and drop
					dispatch_ack_by_way[w] = 1'b1;
				end else if (!taken && !full) begin
					dispatch_ack_by_way[w] = 1'b1;
					taken = 1'b1;
					sel_way = SEL_W'(w);
				end else begin
					// retried later, holds back every higher way
					blocked = 1'b1;
				end
			end
		end
	end

	assign sel_op = dispatch_by_way[sel_way];
	assign write_valid = taken;

	always_comb begin
		write_entry.op = sel_op.op;
		write_entry.imm12 = sel_op.imm12;
		write_entry.mdp_info = sel_op.mdp_info;
		write_entry.A_PR = sel_op.A_PR;
		write_entry.A_ready = sel_op.A_ready;
		write_entry.A_is_zero = sel_op.A_is_zero;
		write_entry.dest_PR = sel_op.dest_PR;
		write_entry.ROB_index = sel_op.ROB_index;
		write_entry.killed = 1'b0;
	end

endmodule

//--- src/ldu_types_pkg.sv
// load dispatch op, dispatch queue entry
// central queue and issue queue enqueue structs

`include "ldu_macros.svh"

package ldu_types_pkg;

	// one dispatch way
	typedef struct packed {
		logic attempt;
		logic valid;
		logic [3:0] op;
		logic [11:0] imm12;
		logic [`LDU_MDPT_INFO_WIDTH-1:0] mdp_info;
		core_types_pkg::pr_t A_PR;
		logic A_ready;
		logic A_is_zero;
		core_types_pkg::pr_t dest_PR;
		core_types_pkg::rob_index_t ROB_index;
	} ldu_dispatch_op_t;

	// stored op, killed set while waiting
	typedef struct packed {
		logic [3:0] op;
		logic [11:0] imm12;
		logic [`LDU_MDPT_INFO_WIDTH-1:0] mdp_info;
		core_types_pkg::pr_t A_PR;
		logic A_ready;
		logic A_is_zero;
		core_types_pkg::pr_t dest_PR;
		core_types_pkg::rob_index_t ROB_index;
		logic killed;
	} ldu_dq_entry_t;

	typedef struct packed {
		logic valid;
		logic killed;
		logic [`LDU_MDPT_INFO_WIDTH-1:0] mdp_info;
		core_types_pkg::pr_t dest_PR;
		core_types_pkg::rob_index_t ROB_index;
	} ldu_cq_enq_t;

	typedef struct packed {
		logic valid;
		logic [3:0] op;
		logic [11:0] imm12;
		core_types_pkg::pr_t A_PR;
		logic A_ready;
		logic A_is_zero;
		core_types_pkg::cq_index_t cq_index;
	} ldu_iq_enq_t;

endpackage

//--- src/core_types_pkg.sv
// core-wide index types, writeback and kill broadcasts
// plus the wakeup and kill match helpers

`include "ldu_macros.svh"

package core_types_pkg;

	typedef logic [`LDU_LOG_PR_COUNT-1:0] pr_t;
	typedef logic [`LDU_LOG_ROB_ENTRIES-1:0] rob_index_t;
	typedef logic [`LDU_LOG_CQ_ENTRIES-1:0] cq_index_t;

	// one bank slot, the bank itself is the low PR bits
	typedef struct packed {
		logic valid;
		logic [`LDU_LOG_PR_COUNT-`LDU_LOG_PRF_BANK_COUNT-1:0] upper_PR;
	} wb_bus_t;

	typedef wb_bus_t [`LDU_PRF_BANK_COUNT-1:0] wb_bus_by_bank_t;

	typedef struct packed {
		logic valid;
		rob_index_t abs_head_index;
		rob_index_t rel_kill_younger_index;
	} rob_kill_t;

	// operand wakeup from its own bank
	function automatic logic pr_woken(pr_t pr, wb_bus_by_bank_t wb_bus_by_bank);
		wb_bus_t slot;
		slot = wb_bus_by_bank[pr[`LDU_LOG_PRF_BANK_COUNT-1:0]];
		return slot.valid && (slot.upper_PR == pr[`LDU_LOG_PR_COUNT-1:`LDU_LOG_PRF_BANK_COUNT]);
	endfunction

	// younger than or at the kill point, relative to ROB head
	function automatic logic rob_killed(rob_index_t rob_index, rob_kill_t rob_kill);
		rob_index_t rel_index;
		rel_index = rob_index - rob_kill.abs_head_index;
		return rob_kill.valid && (rel_index >= rob_kill.rel_kill_younger_index);
	endfunction

endpackage

//--- src/ldu_macros.svh
// sizing macros for the load dispatch queue
// register file, ROB, central queue, way and bank counts

`ifndef LDU_MACROS_SVH
`define LDU_MACROS_SVH

// dispatch width
`define LDU_DISPATCH_WAYS 4

// physical registers and writeback banking
`define LDU_PR_COUNT 64
`define LDU_LOG_PR_COUNT 6
`define LDU_PRF_BANK_COUNT 4
`define LDU_LOG_PRF_BANK_COUNT 2

// ROB and load central queue
`define LDU_ROB_ENTRIES 32
`define LDU_LOG_ROB_ENTRIES 5
`define LDU_LOG_CQ_ENTRIES 4

`define LDU_MDPT_INFO_WIDTH 8
`define LDU_DQ_ENTRIES 4

`endif
